// ==== verif/vga_testdata.txt ====
# op addr data err (op: 1 write, 2 read with expected data and error, 3 wait addr frames)
# addr and data in hex, op and err in decimal; pixel index i sits at address 4*i
1 00000000 00ff0000 0
1 00000004 0000ff00 0
1 000009fc 000000ff 0
1 00000a00 00123456 0
1 0000c0e4 00abcdef 0
1 000ffffc 00f0e1d2 0
1 00000004 00a5a5a5 0
2 00100000 00000000 0
2 00100004 00000000 0
1 00100004 00000077 1
2 00000000 00000000 0
2 00000a00 00000000 0
1 00100000 00000001 0
2 00100000 00000001 0
3 00000002 00000000 0
2 00100004 00000002 0
1 00100000 00000000 0
3 00000002 00000000 0
2 00100004 00000004 0
2 00100000 00000000 0
1 00000008 007f7f7f 0
1 00100000 00000001 0
3 00000002 00000000 0
2 00100004 00000006 0

// ==== all.f ====
+incdir+common
common/vga_pkg.sv
apb/apb_fb_port.sv
design/frame_buffer.sv
vga/vga_scan_timing.sv
vga/vga_pixel_out.sv
design/vga_apb_top.sv
verif/tb_clock_gen.sv
verif/vga_checker.sv
verif/vga_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vga_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: sim clean

sim:
	$(VERILATOR) --binary -j 0 --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) $(VFLAGS)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/vga_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_tb;

    logic        pclk;
    logic        reset;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_hsync;
    logic        vga_vsync;
    logic        vga_valid;
    logic        exp_valid;
    logic [31:0] exp_data;
    logic        exp_err;
    logic        done;
    int          errors;
    logic        timed_out;

    tb_clock_gen u_clock_gen (
        .pclk  (pclk),
        .reset (reset)
    );

    vga_apb_top DUT (
        .pclk      (pclk),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_valid (vga_valid)
    );

    vga_checker u_checker (
        .pclk      (pclk),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_valid (vga_valid),
        .exp_valid (exp_valid),
        .exp_data  (exp_data),
        .exp_err   (exp_err),
        .done      (done),
        .errors    (errors)
    );

    // one APB transfer with setup and access on falling edges
    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] data);
        int n;
        n = 0;
        @(negedge pclk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = wr;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge pclk);
        penable = 1'b1;
        do
        begin
            @(posedge pclk);
            n = n + 1;
        end
        while (!pready && n < 16);
        if (!pready)
        begin
            $display("timeout: pready never rose for address 0x%08h", addr);
            timed_out = 1'b1;
        end
        @(negedge pclk);
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic wait_frames(input int count);
        int   cycles;
        logic prev;
        for (int i = 0; i < count && !timed_out; i++)
        begin
            cycles = 0;
            prev   = vga_vsync;
            forever
            begin
                @(negedge pclk);
                if (prev && !vga_vsync)
                    break;
                prev   = vga_vsync;
                cycles = cycles + 1;
                if (cycles > 900000)
                begin
                    $display("timeout: no vsync falling edge within %0d cycles", cycles);
                    timed_out = 1'b1;
                    break;
                end
            end
        end
    endtask

    task automatic run_file();
        int          fd;
        int          op;
        int          err;
        int          got;
        logic [31:0] addr;
        logic [31:0] data;
        string       line;
        fd = $fopen("verif/vga_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("could not open verif/vga_testdata.txt");
            timed_out = 1'b1;
            return;
        end
        while (!$feof(fd) && !timed_out)
        begin
            line = "";
            void'($fgets(line, fd));
            got = $sscanf(line, "%d %h %h %d", op, addr, data, err);
            if (got != 4)
                continue;   // comment or blank line
            case (op)
                1:
                begin
                    exp_valid = 1'b1;
                    exp_err   = err[0];
                    apb_transfer(1'b1, addr, data);
                end
                2:
                begin
                    exp_valid = 1'b1;
                    exp_data  = data;
                    exp_err   = err[0];
                    apb_transfer(1'b0, addr, 32'd0);
                end
                3: wait_frames(int'(addr));
                default: $display("unknown op %0d in data file", op);
            endcase
        end
        $fclose(fd);
    endtask

    initial
    begin
        int n;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        exp_valid = 1'b0;
        exp_data  = '0;
        exp_err   = 1'b0;
        done      = 1'b0;
        timed_out = 1'b0;
        n = 0;
        do
        begin
            @(negedge pclk);
            n = n + 1;
        end
        while (reset && n < 20);
        if (reset)
        begin
            $display("timeout: reset never released");
            timed_out = 1'b1;
        end
        if (!timed_out)
            run_file();
        done = 1'b1;
        @(negedge pclk);
        @(negedge pclk);
        if (errors == 0 && !timed_out)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/vga_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module vga_checker
(
    input  wire logic        pclk,
    input  wire logic        reset,
    input  wire logic [31:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    input  wire logic        pready,
    input  wire logic [31:0] prdata,
    input  wire logic        pslverr,
    input  wire logic [7:0]  vga_r,
    input  wire logic [7:0]  vga_g,
    input  wire logic [7:0]  vga_b,
    input  wire logic        vga_hsync,
    input  wire logic        vga_vsync,
    input  wire logic        vga_valid,
    input  wire logic        exp_valid,
    input  wire logic [31:0] exp_data,
    input  wire logic        exp_err,
    input  wire logic        done,
    output int               errors
);

    logic [23:0] model_pix [int];
    logic        model_ctrl;
    logic        ctrl_prev;
    logic [2:0]  en_hist;   // ctrl level over the last three edges
    int          model_frames;
    logic        frame_seen;
    logic        line_seen;
    logic        frame_on;
    logic        check_frame;
    logic        hs_prev;
    logic        vs_prev;
    int          line_cycles;
    int          hs_low;
    int          vs_low;
    int          valid_in_line;
    int          lines_valid;
    int          pix_idx;
    int          pix_checks;
    int          read_checks;
    logic [31:0] exp_rd;
    logic        exp_slverr;
    logic [23:0] colour;

    task automatic flag(input string msg);
        errors = errors + 1;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    initial
        errors = 0;

    always @(posedge pclk)
    begin
        colour = {vga_r, vga_g, vga_b};
        if (reset)
        begin
            model_pix.delete();
            model_ctrl    = 1'b0;
            en_hist       = '0;
            model_frames  = 0;
            frame_seen    = 1'b0;
            line_seen     = 1'b0;
            frame_on      = 1'b0;
            check_frame   = 1'b0;
            hs_prev       = 1'b0;
            vs_prev       = 1'b0;
            line_cycles   = 0;
            hs_low        = 0;
            vs_low        = 0;
            valid_in_line = 0;
            lines_valid   = 0;
            pix_idx       = 0;
            pix_checks    = 0;
            read_checks   = 0;
        end
        else
        begin
            ctrl_prev = model_ctrl;
            if (pready !== (psel && penable))
                flag($sformatf("pready %b with psel %b penable %b", pready, psel, penable));
            if (psel && penable)
            begin
                if (pwrite)
                begin
                    exp_slverr = (!paddr[20] && {13'd0, paddr[20:2]} >= 32'(`FB_DEPTH)) ||
                                 (paddr[20] && paddr[19:2] == 18'(`REG_FRAME_OFFSET));
                    if (pslverr !== exp_slverr)
                        flag($sformatf("write 0x%08h pslverr %b, expected %b",
                                       paddr, pslverr, exp_slverr));
                    if (exp_valid && pslverr !== exp_err)
                        flag($sformatf("write 0x%08h pslverr %b, data file %b",
                                       paddr, pslverr, exp_err));
                    if (!exp_slverr && !paddr[20])
                    begin
                        model_pix[int'(paddr[20:2])] = pwdata[23:0];
                        check_frame = 1'b0;   // rest of this frame may race the write
                    end
                    else if (paddr[20] && paddr[19:2] == 18'(`REG_CTRL_OFFSET))
                        model_ctrl = pwdata[0];
                end
                else
                begin
                    exp_rd = '0;
                    if (paddr[20] && paddr[19:2] == 18'(`REG_CTRL_OFFSET))
                        exp_rd = {31'd0, model_ctrl};
                    else if (paddr[20] && paddr[19:2] == 18'(`REG_FRAME_OFFSET))
                        exp_rd = model_frames;
                    read_checks = read_checks + 1;
                    if (prdata !== exp_rd)
                        flag($sformatf("read 0x%08h got 0x%08h, model 0x%08h",
                                       paddr, prdata, exp_rd));
                    if (exp_valid && prdata !== exp_data)
                        flag($sformatf("read 0x%08h got 0x%08h, data file 0x%08h",
                                       paddr, prdata, exp_data));
                    if (pslverr !== 1'b0 || (exp_valid && pslverr !== exp_err))
                        flag($sformatf("read 0x%08h pslverr %b", paddr, pslverr));
                end
            end

            // line period and sync width from hsync edges
            if (hs_prev && !vga_hsync)
            begin
                if (line_seen && line_cycles != `VGA_H_TOTAL)
                    flag($sformatf("line period %0d cycles", line_cycles));
                if (line_seen && valid_in_line != 0 && valid_in_line != `VGA_H_PIXELS)
                    flag($sformatf("%0d valid cycles in a line", valid_in_line));
                if (valid_in_line > 0)
                    lines_valid = lines_valid + 1;
                line_seen     = 1'b1;
                line_cycles   = 1;
                hs_low        = 1;
                valid_in_line = 0;
            end
            else
            begin
                line_cycles = line_cycles + 1;
                if (!hs_prev && vga_hsync && line_seen && hs_low != `VGA_H_SYNC_END)
                    flag($sformatf("hsync low for %0d cycles", hs_low));
                if (!vga_hsync)
                    hs_low = hs_low + 1;
            end

            // vsync edges mark frames
            if (vs_prev && !vga_vsync)
            begin
                if (frame_seen && lines_valid != 480)
                    flag($sformatf("%0d lines with valid pixels in a frame", lines_valid));
                if (frame_seen && pix_idx != `FB_DEPTH)
                    flag($sformatf("%0d valid pixels in a frame", pix_idx));
                frame_seen   = 1'b1;
                model_frames = model_frames + 1;
                frame_on     = en_hist[2];
                check_frame  = 1'b1;
                pix_idx      = 0;
                lines_valid  = 0;
                vs_low       = 1;
            end
            else
            begin
                if (!vs_prev && vga_vsync && frame_seen &&
                    vs_low != 2 * `VGA_H_TOTAL)
                    flag($sformatf("vsync low for %0d cycles", vs_low));
                if (!vga_vsync)
                    vs_low = vs_low + 1;
            end

            if (vga_valid)
            begin
                if (frame_seen && !frame_on && colour !== 24'd0)
                    flag($sformatf("pixel %0d not blanked: 0x%06h", pix_idx, colour));
                else if (frame_seen && frame_on && check_frame && model_pix.exists(pix_idx))
                begin
                    pix_checks = pix_checks + 1;
                    if (colour !== model_pix[pix_idx])
                        flag($sformatf("pixel %0d shows 0x%06h, expected 0x%06h",
                                       pix_idx, colour, model_pix[pix_idx]));
                end
                pix_idx       = pix_idx + 1;
                valid_in_line = valid_in_line + 1;
            end
            else if (colour !== 24'd0)
                flag($sformatf("colour 0x%06h outside active area", colour));

            hs_prev = vga_hsync;
            vs_prev = vga_vsync;
            en_hist = {en_hist[1:0], ctrl_prev};
        end
    end

    always @(posedge done)
    begin
        if (pix_checks == 0)
            flag("no written pixel was ever displayed");
        $display("checker: %0d errors, %0d pixel checks, %0d read checks, %0d frames",
                 errors, pix_checks, read_checks, model_frames);
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
    output logic pclk,
    output logic reset
);

    initial
    begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;   // 100 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge pclk);
        @(negedge pclk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== design/vga_apb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_apb_top
    import vga_pkg::*;
(
    input  wire logic        pclk,
    input  wire logic        reset,
    input  wire logic [31:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic             pready,
    output logic [31:0]      prdata,
    output logic             pslverr,
    output logic [7:0]       vga_r,
    output logic [7:0]       vga_g,
    output logic [7:0]       vga_b,
    output logic             vga_hsync,
    output logic             vga_vsync,
    output logic             vga_valid
);

    fb_write_s fb_write;
    logic      display_enable;
    logic      frame_start;
    fb_addr_t  rd_addr;
    pixel_t    rd_data;
    scan_pos_s scan;

    apb_fb_port u_apb_fb_port (
        .pclk           (pclk),
        .reset          (reset),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .pready         (pready),
        .prdata         (prdata),
        .pslverr        (pslverr),
        .frame_start    (frame_start),
        .fb_write       (fb_write),
        .display_enable (display_enable)
    );

    frame_buffer u_frame_buffer (
        .pclk     (pclk),
        .fb_write (fb_write),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    vga_scan_timing u_vga_scan_timing (
        .pclk        (pclk),
        .reset       (reset),
        .scan        (scan),
        .rd_addr     (rd_addr),
        .frame_start (frame_start)
    );

    vga_pixel_out u_vga_pixel_out (
        .pclk           (pclk),
        .reset          (reset),
        .scan           (scan),
        .rd_data        (rd_data),
        .frame_start    (frame_start),
        .display_enable (display_enable),
        .vga_r          (vga_r),
        .vga_g          (vga_g),
        .vga_b          (vga_b),
        .vga_hsync      (vga_hsync),
        .vga_vsync      (vga_vsync),
        .vga_valid      (vga_valid)
    );

endmodule

`default_nettype wire

// ==== vga/vga_pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_pixel_out
    import vga_pkg::*;
(
    input  wire logic      pclk,
    input  wire logic      reset,
    input  wire scan_pos_s scan,
    input  wire pixel_t    rd_data,
    input  wire logic      frame_start,
    input  wire logic      display_enable,
    output logic [7:0]     vga_r,
    output logic [7:0]     vga_g,
    output logic [7:0]     vga_b,
    output logic           vga_hsync,
    output logic           vga_vsync,
    output logic           vga_valid
);

    scan_pos_s scan_d;    // lines up with rd_data
    logic      frame_en;
    pixel_t    pix_q;

    always_ff @(posedge pclk)
    begin
        if (reset)
        begin
            scan_d    <= '0;
            frame_en  <= 1'b0;
            pix_q     <= '0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
            vga_valid <= 1'b0;
        end
        else
        begin
            scan_d <= scan;
            if (frame_start)
                frame_en <= display_enable;   // whole frame shown or blanked
            pix_q     <= (frame_en & scan_d.active) ? rd_data : '0;
            vga_hsync <= scan_d.hsync;
            vga_vsync <= scan_d.vsync;
            vga_valid <= scan_d.active;
        end
    end

    assign vga_r = pix_q[23:16];
    assign vga_g = pix_q[15:8];
    assign vga_b = pix_q[7:0];

endmodule

`default_nettype wire

// ==== vga/vga_scan_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module vga_scan_timing
    import vga_pkg::*;
(
    input  wire logic pclk,
    input  wire logic reset,
    output scan_pos_s scan,
    output fb_addr_t  rd_addr,
    output logic      frame_start
);

    coord_t x_cnt;
    coord_t y_cnt;
    logic   line_end;
    logic   h_active;
    logic   v_active;
    coord_t col;
    coord_t row;

    assign line_end = (x_cnt == coord_t'(`VGA_H_TOTAL));

    // both counters are 1-based
    always_ff @(posedge pclk)
    begin
        if (reset)
            x_cnt <= coord_t'(1);
        else if (line_end)
            x_cnt <= coord_t'(1);
        else
            x_cnt <= x_cnt + coord_t'(1);
    end

    always_ff @(posedge pclk)
    begin
        if (reset)
            y_cnt <= coord_t'(1);
        else if (line_end)
        begin
            if (y_cnt == coord_t'(`VGA_V_TOTAL))
                y_cnt <= coord_t'(1);
            else
                y_cnt <= y_cnt + coord_t'(1);
        end
    end

    assign frame_start = line_end & (y_cnt == coord_t'(`VGA_V_TOTAL));

    assign h_active = (x_cnt >= coord_t'(`VGA_H_ACT_START)) &
                      (x_cnt <= coord_t'(`VGA_H_ACT_END));
    assign v_active = (y_cnt >= coord_t'(`VGA_V_ACT_START)) &
                      (y_cnt <= coord_t'(`VGA_V_ACT_END));

    assign scan.hsync  = (x_cnt > coord_t'(`VGA_H_SYNC_END));   // low during sync pulse
    assign scan.vsync  = (y_cnt > coord_t'(`VGA_V_SYNC_END));
    assign scan.active = h_active & v_active;

    assign col = x_cnt - coord_t'(`VGA_H_ACT_START);
    assign row = y_cnt - coord_t'(`VGA_V_ACT_START);

    // raster order, row * 640 + col
    assign rd_addr = scan.active ?
                     fb_addr_t'(row) * fb_addr_t'(`VGA_H_PIXELS) + fb_addr_t'(col) : '0;

endmodule

`default_nettype wire

// ==== design/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module frame_buffer
    import vga_pkg::*;
(
    input  wire logic      pclk,
    input  wire fb_write_s fb_write,
    input  wire fb_addr_t  rd_addr,
    output pixel_t         rd_data
);

    pixel_t mem [0:`FB_DEPTH-1];

    always_ff @(posedge pclk)
    begin
        if (fb_write.en)
            mem[fb_write.addr] <= fb_write.data;
    end

    // scan side, one cycle of latency
    always_ff @(posedge pclk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== apb/apb_fb_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module apb_fb_port
    import vga_pkg::*;
(
    input  wire logic        pclk,
    input  wire logic        reset,
    input  wire logic [31:0] paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic             pready,
    output logic [31:0]      prdata,
    output logic             pslverr,
    input  wire logic        frame_start,
    output fb_write_s        fb_write,
    output logic             display_enable
);

    logic        access;
    logic        fb_sel;
    logic        fb_in_range;
    logic        ctrl_sel;
    logic        frame_sel;
    fb_addr_t    fb_index;
    logic [17:0] reg_word;
    logic        ctrl_en;
    logic [31:0] frame_cnt;

    assign access   = psel & penable;
    assign pready   = access;   // never any wait states

    assign fb_sel      = ~paddr[20];
    assign fb_index    = paddr[20:2];
    assign fb_in_range = (fb_index < fb_addr_t'(`FB_DEPTH));

    assign reg_word  = paddr[19:2];
    assign ctrl_sel  = paddr[20] & (reg_word == 18'(`REG_CTRL_OFFSET));
    assign frame_sel = paddr[20] & (reg_word == 18'(`REG_FRAME_OFFSET));

    // write lands in memory on the edge that closes the access phase
    assign fb_write.en   = access & pwrite & fb_sel & fb_in_range;
    assign fb_write.addr = fb_index;
    assign fb_write.data = pwdata[23:0];

    always_ff @(posedge pclk)
    begin
        if (reset)
            ctrl_en <= 1'b0;
        else if (access & pwrite & ctrl_sel)
            ctrl_en <= pwdata[0];
    end

    always_ff @(posedge pclk)
    begin
        if (reset)
            frame_cnt <= '0;
        else if (frame_start)
            frame_cnt <= frame_cnt + 32'd1;
    end

    assign display_enable = ctrl_en;

    // framebuffer reads come back as zero
    always_comb
    begin
        prdata = '0;
        if (access & ~pwrite)
        begin
            if (ctrl_sel)
                prdata = {31'd0, ctrl_en};
            else if (frame_sel)
                prdata = frame_cnt;
        end
    end

    assign pslverr = access & pwrite & ((fb_sel & ~fb_in_range) | frame_sel);

endmodule

`default_nettype wire

// ==== common/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

    typedef logic [9:0]  coord_t;    // scan count or pixel coordinate
    typedef logic [23:0] pixel_t;    // r 23:16, g 15:8, b 7:0
    typedef logic [18:0] fb_addr_t;  // framebuffer word index

    // one framebuffer write from the bus side
    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        pixel_t   data;
    } fb_write_s;

    // scan flags for the current counter state
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
    } scan_pos_s;

endpackage

`default_nettype wire

// ==== common/vga_defs.svh ====
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

// horizontal scan, 1-based pixel counts
`define VGA_H_SYNC_END    96
`define VGA_H_ACT_START   145
`define VGA_H_ACT_END     784
`define VGA_H_TOTAL       800

// vertical scan, 1-based line counts
`define VGA_V_SYNC_END    2
`define VGA_V_ACT_START   36
`define VGA_V_ACT_END     515
`define VGA_V_TOTAL       525

`define VGA_H_PIXELS      640   // row stride of the framebuffer

`define FB_DEPTH          307200

// word offsets inside the register window (paddr[20] set)
`define REG_CTRL_OFFSET   0
`define REG_FRAME_OFFSET  1

`endif
